// File: hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // address split: tag | index | offset
    localparam int ADDR_W      = 17;    // 128 KiB byte space
    localparam int LINE_BYTES  = 8;
    localparam int OFFSET_W    = 3;
    localparam int SETS        = 256;
    localparam int INDEX_W     = 8;
    localparam int TAG_W       = ADDR_W - 11;
    localparam int LINE_W      = 64;
    localparam int LINE_ADDR_W = 14;    // tag + index

    localparam int XLEN = 32;

    // backing memory, strobe to ack
    localparam int MEM_LATENCY = 4;
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);

    // funct3 access modes
    localparam logic [2:0] MODE_B  = 3'b000;
    localparam logic [2:0] MODE_H  = 3'b001;
    localparam logic [2:0] MODE_W  = 3'b010;
    localparam logic [2:0] MODE_BU = 3'b100;
    localparam logic [2:0] MODE_HU = 3'b101;

endpackage

`default_nettype wire

// File: hdl/mem_req_stage.sv
`default_nettype none

module mem_req_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req,
    input  logic                              we,
    input  logic [2:0]                        mode,
    input  logic [dcache_pkg::ADDR_W-1:0]     addr,
    input  logic [dcache_pkg::XLEN-1:0]       wdata,
    input  logic                              miss_stall,
    output logic                              s1_valid,
    output logic                              s1_we,
    output logic [2:0]                        s1_mode,
    output logic [dcache_pkg::ADDR_W-1:0]     s1_addr,
    output logic [dcache_pkg::LINE_W-1:0]     s1_wdata64,
    output logic [dcache_pkg::LINE_BYTES-1:0] s1_be
);
    import dcache_pkg::*;

    logic                  accept;
    logic [ADDR_W-1:0]     aligned_addr;
    logic [LINE_BYTES-1:0] be_base;
    logic [LINE_W-1:0]     lane_data;

    assign accept = req && !miss_stall;

    // misaligned addresses are forced to natural alignment
    always_comb begin
        aligned_addr = addr;
        case (mode)
            MODE_H, MODE_HU: begin
                aligned_addr[0] = 1'b0;
                be_base         = LINE_BYTES'(2'b11);
                lane_data       = {4{wdata[15:0]}};
            end
            MODE_W: begin
                aligned_addr[1:0] = 2'b00;
                be_base           = LINE_BYTES'(4'hf);
                lane_data         = {2{wdata}};
            end
            default: begin  // byte modes
                be_base   = LINE_BYTES'(1'b1);
                lane_data = {8{wdata[7:0]}};
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (!miss_stall) begin
            s1_valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_we      <= we;
            s1_mode    <= mode;
            s1_addr    <= aligned_addr;
            s1_wdata64 <= lane_data;    // enables pick the lane
            s1_be      <= we ? (be_base << aligned_addr[OFFSET_W-1:0]) : '0;
        end
    end

    // stage frozen while the cache works on a miss
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        miss_stall |=> $stable({s1_valid, s1_we, s1_mode, s1_addr, s1_wdata64, s1_be})
    );

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               s1_valid,
    input  logic                               s1_we,
    input  logic [2:0]                         s1_mode,
    input  logic [dcache_pkg::ADDR_W-1:0]      s1_addr,
    input  logic [dcache_pkg::LINE_W-1:0]      s1_wdata64,
    input  logic [dcache_pkg::LINE_BYTES-1:0]  s1_be,
    output logic                               miss_stall,
    output logic                               s2_valid,
    output logic                               s2_we,
    output logic [2:0]                         s2_mode,
    output logic [dcache_pkg::OFFSET_W-1:0]    s2_offset,
    output logic [dcache_pkg::LINE_W-1:0]      s2_line,
    output logic                               mem_rd,
    output logic                               mem_wr,
    output logic [dcache_pkg::LINE_ADDR_W-1:0] mem_line_addr,
    output logic [dcache_pkg::LINE_W-1:0]      mem_wdata,
    input  logic                               mem_ack,
    input  logic [dcache_pkg::LINE_W-1:0]      mem_rdata
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } state_t;

    state_t state;
    state_t next_state;

    logic [LINE_W-1:0] line_array [0:SETS-1];
    logic [TAG_W-1:0]  tag_array  [0:SETS-1];
    logic [SETS-1:0]   valid_bits;
    logic [SETS-1:0]   dirty_bits;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [LINE_W-1:0]  cur_line;
    logic [LINE_W-1:0]  merged_line;
    logic               hit;
    logic               compare_hit;
    logic               refill_done;
    logic               mem_issued;     // strobe sent, waiting for ack

    assign index       = s1_addr[OFFSET_W +: INDEX_W];
    assign tag         = s1_addr[ADDR_W-1 -: TAG_W];
    assign cur_line    = line_array[index];
    assign hit         = valid_bits[index] && (tag_array[index] == tag);
    assign compare_hit = (state == COMPARE) && s1_valid && hit;
    assign refill_done = (state == ALLOCATE) && mem_ack;

    // store bytes over the resident line, loads pass it unchanged
    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            merged_line[8*i +: 8] = s1_be[i] ? s1_wdata64[8*i +: 8] : cur_line[8*i +: 8];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = COMPARE;
            COMPARE: begin
                if (s1_valid && !hit) begin
                    next_state = dirty_bits[index] ? WRITE_BACK : ALLOCATE;
                end
            end
            WRITE_BACK: begin
                if (mem_ack) next_state = ALLOCATE;
            end
            ALLOCATE: begin
                if (mem_ack) next_state = COMPARE;     // retry the request
            end
            default: next_state = IDLE;
        endcase
    end

    assign miss_stall = (state == COMPARE && s1_valid && !hit)
                        || state == WRITE_BACK
                        || state == ALLOCATE;

    assign mem_wr        = (state == WRITE_BACK) && !mem_issued;
    assign mem_rd        = (state == ALLOCATE) && !mem_issued;
    assign mem_line_addr = (state == WRITE_BACK) ? {tag_array[index], index} : {tag, index};
    assign mem_wdata     = cur_line;   // victim line

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            valid_bits <= '0;
            dirty_bits <= '0;
            mem_issued <= 1'b0;
            s2_valid   <= 1'b0;
        end else begin
            state    <= next_state;
            s2_valid <= compare_hit;
            if (mem_rd || mem_wr) begin
                mem_issued <= 1'b1;
            end else if (mem_ack) begin
                mem_issued <= 1'b0;
            end
            if (compare_hit && s1_we) begin
                dirty_bits[index] <= 1'b1;
            end
            if (refill_done) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;  // fresh line is clean
            end
        end
    end

    always_ff @(posedge clk) begin
        if (compare_hit && s1_we) begin
            line_array[index] <= merged_line;
        end else if (refill_done) begin
            line_array[index] <= mem_rdata;
            tag_array[index]  <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (compare_hit) begin
            s2_we     <= s1_we;
            s2_mode   <= s1_mode;
            s2_offset <= s1_addr[OFFSET_W-1:0];
            s2_line   <= merged_line;
        end
    end

    a_strobe_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_rd && mem_wr)
    );

    // responses only while a miss is in service
    a_ack_in_miss: assert property (
        @(posedge clk) disable iff (rst)
        mem_ack |-> (state inside {WRITE_BACK, ALLOCATE})
    );

    a_no_stall_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == IDLE) |-> !miss_stall
    );

endmodule

`default_nettype wire

// File: hdl/load_align_stage.sv
`default_nettype none

module load_align_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            s2_valid,
    input  logic                            s2_we,
    input  logic [2:0]                      s2_mode,
    input  logic [dcache_pkg::OFFSET_W-1:0] s2_offset,
    input  logic [dcache_pkg::LINE_W-1:0]   s2_line,
    output logic [dcache_pkg::XLEN-1:0]     rdata,
    output logic                            rdata_valid,
    output logic                            done
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] shifted;
    logic [XLEN-1:0]   ext_data;

    // addressed byte lands in bit 0
    assign shifted = s2_line >> {s2_offset, 3'b000};

    always_comb begin
        case (s2_mode)
            MODE_B:  ext_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            MODE_H:  ext_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            MODE_BU: ext_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
            MODE_HU: ext_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: ext_data = shifted[XLEN-1:0];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            rdata_valid <= s2_valid && !s2_we;
            done        <= s2_valid;     // every request, load or store
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid && !s2_we) begin
            rdata <= ext_data;
        end
    end

    a_valid_has_done: assert property (
        @(posedge clk) disable iff (rst)
        rdata_valid |-> done
    );

endmodule

`default_nettype wire

// File: hdl/main_mem.sv
`default_nettype none

module main_mem (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               mem_rd,
    input  logic                               mem_wr,
    input  logic [dcache_pkg::LINE_ADDR_W-1:0] mem_line_addr,
    input  logic [dcache_pkg::LINE_W-1:0]      mem_wdata,
    output logic                               mem_ack,
    output logic [dcache_pkg::LINE_W-1:0]      mem_rdata
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] mem_array [0:(2**LINE_ADDR_W)-1] = '{default: '0};

    logic [MEM_CNT_W-1:0]   count;     // cycles left to ack
    logic [LINE_ADDR_W-1:0] addr_q;
    logic                   ack_next;

    assign ack_next = (count == MEM_CNT_W'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= '0;
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= ack_next;
            if (mem_rd || mem_wr) begin
                count <= MEM_CNT_W'(MEM_LATENCY - 1);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem_array[mem_line_addr] <= mem_wdata;
        end
        if (mem_rd || mem_wr) begin
            addr_q <= mem_line_addr;
        end
        if (ack_next) begin
            mem_rdata <= mem_array[addr_q];     // valid with ack
        end
    end

    a_one_pending: assert property (
        @(posedge clk) disable iff (rst)
        (mem_rd || mem_wr) |-> (count == '0)
    );

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  logic                          we,
    input  logic [2:0]                    mode,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  logic [dcache_pkg::XLEN-1:0]   wdata,
    output logic                          miss_stall,
    output logic [dcache_pkg::XLEN-1:0]   rdata,
    output logic                          rdata_valid,
    output logic                          done
);
    import dcache_pkg::*;

    // request stage to controller
    logic                  s1_valid;
    logic                  s1_we;
    logic [2:0]            s1_mode;
    logic [ADDR_W-1:0]     s1_addr;
    logic [LINE_W-1:0]     s1_wdata64;
    logic [LINE_BYTES-1:0] s1_be;

    // controller to load alignment
    logic                s2_valid;
    logic                s2_we;
    logic [2:0]          s2_mode;
    logic [OFFSET_W-1:0] s2_offset;
    logic [LINE_W-1:0]   s2_line;

    logic                   mem_rd;
    logic                   mem_wr;
    logic [LINE_ADDR_W-1:0] mem_line_addr;
    logic [LINE_W-1:0]      mem_wdata;
    logic                   mem_ack;
    logic [LINE_W-1:0]      mem_rdata;

    mem_req_stage i_mem_req_stage (
        .clk, .rst, .req, .we, .mode, .addr, .wdata, .miss_stall,
        .s1_valid, .s1_we, .s1_mode, .s1_addr, .s1_wdata64, .s1_be
    );

    dcache_ctrl i_dcache_ctrl (
        .clk, .rst,
        .s1_valid, .s1_we, .s1_mode, .s1_addr, .s1_wdata64, .s1_be,
        .miss_stall,
        .s2_valid, .s2_we, .s2_mode, .s2_offset, .s2_line,
        .mem_rd, .mem_wr, .mem_line_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    load_align_stage i_load_align_stage (
        .clk, .rst,
        .s2_valid, .s2_we, .s2_mode, .s2_offset, .s2_line,
        .rdata, .rdata_valid, .done
    );

    main_mem i_main_mem (
        .clk, .rst, .mem_rd, .mem_wr, .mem_line_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;             // release clear of both edges
    end

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int GOLDEN_MAX    = 64;
    localparam int RAND_OPS      = 160;
    localparam int CYCLES_PER_OP = 2 * (MEM_LATENCY + 1) + 4;  // dirty miss plus pipeline

    logic              clk;
    logic              rst;
    logic              req;
    logic              we;
    logic [2:0]        mode;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic              miss_stall;
    logic [XLEN-1:0]   rdata;
    logic              rdata_valid;
    logic              done;

    // kind | mode | addr | store data | expected load value
    logic [91:0] golden [0:GOLDEN_MAX-1];
    logic [7:0]  model_mem [0:(2**ADDR_W)-1];

    integer seed        = 57529;
    int     cycle       = 0;
    int     cycle_limit = 0;
    int     errors      = 0;
    int     sent_count  = 0;
    int     done_count  = 0;

    // requests in flight, oldest first
    string       q_name [$];
    int          q_kind [$];
    logic [31:0] q_expect [$];
    bit          q_load [$];
    int          q_accept [$];
    bit          q_stalled [$];

    clk_gen #(.RESET_CYCLES(RESET_CYCLES)) i_clk_gen (.clk(clk), .rst(rst));

    dcache_top i_dcache_top (
        .clk, .rst, .req, .we, .mode, .addr, .wdata,
        .miss_stall, .rdata, .rdata_valid, .done
    );

    function automatic logic [ADDR_W-1:0] natural_addr(input logic [2:0] m,
                                                       input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] r;
        r = a;
        if (m == MODE_H || m == MODE_HU)
            r[0] = 1'b0;
        else if (m == MODE_W)
            r[1:0] = 2'b00;
        return r;
    endfunction

    function automatic int access_bytes(input logic [2:0] m);
        if (m == MODE_W)
            return 4;
        if (m == MODE_H || m == MODE_HU)
            return 2;
        return 1;
    endfunction

    function automatic logic [2:0] mode_from_index(input int sel);
        case (sel)
            0: return MODE_B;
            1: return MODE_H;
            2: return MODE_W;
            3: return MODE_BU;
            default: return MODE_HU;
        endcase
    endfunction

    task automatic model_store(input logic [2:0] m, input logic [ADDR_W-1:0] a,
                               input logic [31:0] d);
        logic [ADDR_W-1:0] base;
        base = natural_addr(m, a);
        for (int i = 0; i < access_bytes(m); i++)
            model_mem[base + i] = d[8*i +: 8];
    endtask

    function automatic logic [31:0] model_load(input logic [2:0] m, input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] base;
        logic [31:0]       v;
        base = natural_addr(m, a);
        v = '0;
        for (int i = 0; i < access_bytes(m); i++)
            v[8*i +: 8] = model_mem[base + i];
        if (m == MODE_B && v[7])
            v[31:8] = '1;
        if (m == MODE_H && v[15])
            v[31:16] = '1;
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("failure: %s", what);
    endtask

    // drive on the falling edge, hold while the cache stalls
    task automatic send_op(input logic is_we, input logic [2:0] m, input logic [ADDR_W-1:0] a,
                           input logic [31:0] d, input logic [31:0] exp_val,
                           input int kind, input string name);
        @(negedge clk);
        req   = 1'b1;
        we    = is_we;
        mode  = m;
        addr  = a;
        wdata = d;
        while (miss_stall)
            @(negedge clk);
        q_name.push_back(name);
        q_kind.push_back(kind);
        q_expect.push_back(exp_val);
        q_load.push_back(!is_we);
        q_accept.push_back(cycle + 1);  // taken at the coming rising edge
        q_stalled.push_back(1'b0);
        sent_count++;
    endtask

    task automatic go_idle();
        @(negedge clk);
        req = 1'b0;
        we  = 1'b0;
    endtask

    task automatic retire_request();
        string       name;
        int          kind;
        logic [31:0] expected;
        bit          is_load;
        int          accepted;
        bit          stalled;
        name     = q_name.pop_front();
        kind     = q_kind.pop_front();
        expected = q_expect.pop_front();
        is_load  = q_load.pop_front();
        accepted = q_accept.pop_front();
        stalled  = q_stalled.pop_front();
        check_value({name, " rdata_valid"}, is_load, rdata_valid);
        if (is_load)
            check_value(name, expected, rdata);
        if (kind == 2)
            check_value({name, " hit latency"}, 2, cycle - accepted);
        if (kind == 3 && !stalled)
            note_failure({name, " should have missed but miss_stall never rose"});
        if (miss_stall && q_name.size() == 0)
            note_failure({name, " finished while its own miss was still stalling"});
    endtask

    // outputs are registered, so look at them on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (miss_stall) begin
                if (q_name.size() == 0)
                    note_failure("miss_stall is high with no request in flight");
                else
                    q_stalled[q_stalled.size() - 1] = 1'b1;  // newest sits in compare
            end
            if (rdata_valid && !done)
                note_failure("rdata_valid pulsed without done");
            if (done) begin
                done_count++;
                if (q_name.size() == 0)
                    note_failure("done pulsed with no request outstanding");
                else
                    retire_request();
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit != 0 && cycle > cycle_limit) begin
            $display("timeout: run hung waiting for done after %0d cycles", cycle);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int                n_golden;
        logic [91:0]       rec;
        logic [3:0]        kind;
        logic [2:0]        m;
        logic [ADDR_W-1:0] a;
        logic [31:0]       d;
        logic [31:0]       e;
        logic              is_we;
        int                rtag;
        int                ridx;
        int                roff;

        req   = 1'b0;
        we    = 1'b0;
        mode  = 3'b000;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 2**ADDR_W; i++)
            model_mem[i] = 8'h00;   // backing memory starts zeroed
        for (int i = 0; i < GOLDEN_MAX; i++)
            golden[i] = '1;
        $readmemh("bench/dcache_golden.mem", golden);
        n_golden = 0;
        while (n_golden < GOLDEN_MAX && golden[n_golden][91:88] != 4'hf)
            n_golden++;
        if (n_golden == 0)
            note_failure("golden file holds no records");
        cycle_limit = (n_golden + RAND_OPS) * CYCLES_PER_OP + 100 + RESET_CYCLES;

        @(negedge clk);
        while (rst) begin
            check_value("outputs in reset", 0, {miss_stall, rdata_valid, done});
            @(negedge clk);
        end
        repeat (2) begin
            check_value("outputs after reset", 0, {miss_stall, rdata_valid, done});
            @(negedge clk);
        end

        for (int i = 0; i < n_golden; i++) begin
            rec  = golden[i];
            kind = rec[91:88];
            m    = rec[86:84];
            a    = rec[80:64];
            d    = rec[63:32];
            e    = rec[31:0];
            if (kind == 4'h0)
                model_store(m, a, d);
            send_op(kind == 4'h0, m, a, d, e, kind, $sformatf("golden %0d", i));
        end

        // a few sets, four tags each, so lines keep getting evicted
        for (int k = 0; k < RAND_OPS; k++) begin
            is_we = $unsigned($random(seed)) % 2;
            rtag  = $unsigned($random(seed)) % 4;
            ridx  = $unsigned($random(seed)) % 4;
            roff  = $unsigned($random(seed)) % 8;
            a     = ADDR_W'((rtag << 11) | ((8'h40 + ridx) << 3) | roff);
            d     = $random(seed);
            if (is_we) begin
                m = mode_from_index($unsigned($random(seed)) % 3);
                model_store(m, a, d);
                e = '0;
            end else begin
                m = mode_from_index($unsigned($random(seed)) % 5);
                e = model_load(m, a);
            end
            send_op(is_we, m, a, d, e, is_we ? 0 : 1, $sformatf("random %0d", k));
        end

        go_idle();
        while (q_name.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);  // room for a stray done
        check_value("done count", sent_count, done_count);
        $display("run complete: %0d errors, %0d requests, %0d done pulses",
                 errors, sent_count, done_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/dcache_golden.mem
// kind_mode_addr_wdata_expect, kind 0 store, 1 load, 2 load that hits, 3 load that misses, f end
// mode is the funct3 code, addr is a 17-bit byte address
3_2_00040_00000000_00000000
0_2_00080_12345678_00000000
2_2_00080_00000000_12345678
0_0_00081_000000ab_00000000
2_2_00080_00000000_1234ab78
0_1_00082_0000beef_00000000
2_2_00080_00000000_beefab78
2_0_00083_00000000_ffffffbe
2_4_00083_00000000_000000be
2_1_00082_00000000_ffffbeef
2_5_00082_00000000_0000beef
2_0_00080_00000000_00000078
2_2_00083_00000000_beefab78
0_2_00884_cafef00d_00000000
3_2_00080_00000000_beefab78
3_2_00884_00000000_cafef00d
0_2_00084_0badc0de_00000000
2_2_00080_00000000_beefab78
3_2_00884_00000000_cafef00d
3_2_00084_00000000_0badc0de
0_2_00100_89abcdef_00000000
0_2_00104_01234567_00000000
2_2_00104_00000000_01234567
2_2_00100_00000000_89abcdef
2_5_00106_00000000_00000123
2_0_00101_00000000_ffffffcd
2_1_00100_00000000_ffffcdef
f_0_00000_00000000_00000000

// File: filelist.f
hdl/dcache_pkg.sv
hdl/mem_req_stage.sv
hdl/dcache_ctrl.sv
hdl/load_align_stage.sv
hdl/main_mem.sv
hdl/dcache_top.sv
bench/clk_gen.sv
bench/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # design, package first
  - hdl/dcache_pkg.sv
  - hdl/mem_req_stage.sv
  - hdl/dcache_ctrl.sv
  - hdl/load_align_stage.sv
  - hdl/main_mem.sv
  - hdl/dcache_top.sv

  # testbench, top module dcache_tb
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/dcache_tb.sv
